// ==== test/dualPortRam_stim.txt ====
# Columns in hex: selA weNA addrA dataA oeA  selB weNB addrB dataB oeB  expA expB
# expA and expB are the outputs one cycle after the row is driven.
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  00000000000000000000000000000000 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  00000000000000000000000000000000 00000000000000000000000000000000
1 00 05 A057A056A055A054A053A052A051A050 1  0 ff 00 00000000000000000000000000000000 1  A057A056A055A054A053A052A051A050 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  1 ff 05 00000000000000000000000000000000 1  A057A056A055A054A053A052A051A050 A057A056A055A054A053A052A051A050
0 ff 00 00000000000000000000000000000000 1  1 00 10 B107B106B105B104B103B102B101B100 1  A057A056A055A054A053A052A051A050 B107B106B105B104B103B102B101B100
1 ff 10 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  B107B106B105B104B103B102B101B100 B107B106B105B104B103B102B101B100
1 00 4f A4F7A4F6A4F5A4F4A4F3A4F2A4F1A4F0 1  1 00 00 B007B006B005B004B003B002B001B000 1  A4F7A4F6A4F5A4F4A4F3A4F2A4F1A4F0 B007B006B005B004B003B002B001B000
1 ff 00 00000000000000000000000000000000 1  1 ff 4f 00000000000000000000000000000000 1  B007B006B005B004B003B002B001B000 A4F7A4F6A4F5A4F4A4F3A4F2A4F1A4F0
1 00 20 A207A206A205A204A203A202A201A200 1  0 ff 00 00000000000000000000000000000000 1  A207A206A205A204A203A202A201A200 A4F7A4F6A4F5A4F4A4F3A4F2A4F1A4F0
0 ff 00 00000000000000000000000000000000 1  1 00 21 B217B216B215B214B213B212B211B210 1  A207A206A205A204A203A202A201A200 B217B216B215B214B213B212B211B210
1 ff 21 00000000000000000000000000000000 1  1 ff 20 00000000000000000000000000000000 1  B217B216B215B214B213B212B211B210 A207A206A205A204A203A202A201A200
1 f0 05 FFFFFFFFFFFFFFFFC003C002C001C000 1  0 ff 00 00000000000000000000000000000000 1  A057A056A055A054C003C002C001C000 A207A206A205A204A203A202A201A200
0 ff 00 00000000000000000000000000000000 1  1 ff 05 00000000000000000000000000000000 1  A057A056A055A054C003C002C001C000 A057A056A055A054C003C002C001C000
0 ff 00 00000000000000000000000000000000 1  1 55 10 D7D7EEEED5D5EEEED3D3EEEED1D1EEEE 1  A057A056A055A054C003C002C001C000 D7D7B106D5D5B104D3D3B102D1D1B100
1 ff 10 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  D7D7B106D5D5B104D3D3B102D1D1B100 D7D7B106D5D5B104D3D3B102D1D1B100
1 fe 20 99999999999999999999999999991234 1  0 ff 00 00000000000000000000000000000000 1  A207A206A205A204A203A202A2011234 D7D7B106D5D5B104D3D3B102D1D1B100
1 7f 20 87659999999999999999999999999999 1  0 ff 00 00000000000000000000000000000000 1  8765A206A205A204A203A202A2011234 D7D7B106D5D5B104D3D3B102D1D1B100
0 ff 00 00000000000000000000000000000000 1  1 ff 20 00000000000000000000000000000000 1  8765A206A205A204A203A202A2011234 8765A206A205A204A203A202A2011234
1 ff 21 DEADBEEFDEADBEEFDEADBEEFDEADBEEF 1  0 ff 00 00000000000000000000000000000000 1  B217B216B215B214B213B212B211B210 8765A206A205A204A203A202A2011234
1 00 00 E007E006E005E004E003E002E001E000 1  1 00 00 F007F006F005F004F003F002F001F000 1  E007E006E005E004E003E002E001E000 F007F006F005F004F003F002F001F000
0 ff 00 00000000000000000000000000000000 1  1 ff 00 00000000000000000000000000000000 1  E007E006E005E004E003E002E001E000 E007E006E005E004E003E002E001E000
1 0f 4f 11171116111511140000000000000000 1  1 c3 4f 22272226222522242223222222212220 1  1117111611151114A4F3A4F2A4F1A4F0 A4F7A4F62225222422232222A4F1A4F0
1 ff 4f 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  111711161115111422232222A4F1A4F0 A4F7A4F62225222422232222A4F1A4F0
1 00 05 5A075A065A055A045A035A025A015A00 1  1 ff 05 00000000000000000000000000000000 1  5A075A065A055A045A035A025A015A00 A057A056A055A054C003C002C001C000
0 ff 00 00000000000000000000000000000000 1  1 ff 05 00000000000000000000000000000000 1  5A075A065A055A045A035A025A015A00 5A075A065A055A045A035A025A015A00
1 ff 10 00000000000000000000000000000000 1  1 00 10 6B076B066B056B046B036B026B016B00 1  D7D7B106D5D5B104D3D3B102D1D1B100 6B076B066B056B046B036B026B016B00
1 ff 10 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  6B076B066B056B046B036B026B016B00 6B076B066B056B046B036B026B016B00
0 ff 00 00000000000000000000000000000000 0  0 ff 00 00000000000000000000000000000000 1  00000000000000000000000000000000 6B076B066B056B046B036B026B016B00
0 ff 00 00000000000000000000000000000000 0  0 ff 00 00000000000000000000000000000000 0  00000000000000000000000000000000 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 0  6B076B066B056B046B036B026B016B00 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  6B076B066B056B046B036B026B016B00 6B076B066B056B046B036B026B016B00
1 ff 20 00000000000000000000000000000000 0  0 ff 00 00000000000000000000000000000000 1  00000000000000000000000000000000 6B076B066B056B046B036B026B016B00
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  8765A206A205A204A203A202A2011234 6B076B066B056B046B036B026B016B00
0 ff 00 00000000000000000000000000000000 1  1 00 21 7C077C067C057C047C037C027C017C00 0  8765A206A205A204A203A202A2011234 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  8765A206A205A204A203A202A2011234 7C077C067C057C047C037C027C017C00
1 00 50 DEADBEEFDEADBEEFDEADBEEFDEADBEEF 1  0 ff 00 00000000000000000000000000000000 1  00000000000000000000000000000000 7C077C067C057C047C037C027C017C00
0 ff 00 00000000000000000000000000000000 1  1 ff 10 00000000000000000000000000000000 1  00000000000000000000000000000000 6B076B066B056B046B036B026B016B00
0 ff 00 00000000000000000000000000000000 1  1 00 60 CAFEF00DCAFEF00DCAFEF00DCAFEF00D 1  00000000000000000000000000000000 00000000000000000000000000000000
1 ff 20 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  8765A206A205A204A203A202A2011234 00000000000000000000000000000000
1 ff 7f 00000000000000000000000000000000 1  1 ff 4f 00000000000000000000000000000000 1  00000000000000000000000000000000 111711161115111422232222A4F1A4F0
0 ff 00 00000000000000000000000000000000 1  1 ff 50 00000000000000000000000000000000 1  00000000000000000000000000000000 00000000000000000000000000000000
1 00 4f 4F074F064F054F044F034F024F014F00 1  1 ff 50 00000000000000000000000000000000 1  4F074F064F054F044F034F024F014F00 00000000000000000000000000000000
1 ff 00 00000000000000000000000000000000 1  1 ff 4f 00000000000000000000000000000000 1  E007E006E005E004E003E002E001E000 4F074F064F054F044F034F024F014F00
1 00 30 A307A306A305A304A303A302A301A300 1  1 00 31 B317B316B315B314B313B312B311B310 1  A307A306A305A304A303A302A301A300 B317B316B315B314B313B312B311B310
1 00 32 A327A326A325A324A323A322A321A320 1  1 00 33 B337B336B335B334B333B332B331B330 1  A327A326A325A324A323A322A321A320 B337B336B335B334B333B332B331B330
1 00 34 A347A346A345A344A343A342A341A340 1  1 00 35 B357B356B355B354B353B352B351B350 1  A347A346A345A344A343A342A341A340 B357B356B355B354B353B352B351B350
1 00 36 A367A366A365A364A363A362A361A360 1  1 00 37 B377B376B375B374B373B372B371B370 1  A367A366A365A364A363A362A361A360 B377B376B375B374B373B372B371B370
1 ff 31 00000000000000000000000000000000 1  1 ff 30 00000000000000000000000000000000 1  B317B316B315B314B313B312B311B310 A307A306A305A304A303A302A301A300
1 ff 33 00000000000000000000000000000000 1  1 ff 32 00000000000000000000000000000000 1  B337B336B335B334B333B332B331B330 A327A326A325A324A323A322A321A320
1 ff 35 00000000000000000000000000000000 1  1 ff 34 00000000000000000000000000000000 1  B357B356B355B354B353B352B351B350 A347A346A345A344A343A342A341A340
1 ff 37 00000000000000000000000000000000 1  1 ff 36 00000000000000000000000000000000 1  B377B376B375B374B373B372B371B370 A367A366A365A364A363A362A361A360
1 f0 30 00000000000000001113111211111110 1  1 0f 30 22272226222522240000000000000000 1  A307A306A305A3041113111211111110 2227222622252224A303A302A301A300
1 ff 30 00000000000000000000000000000000 1  1 ff 30 00000000000000000000000000000000 1  22272226222522241113111211111110 22272226222522241113111211111110
1 ff 31 00000000000000000000000000000000 1  1 ff 31 00000000000000000000000000000000 1  B317B316B315B314B313B312B311B310 B317B316B315B314B313B312B311B310
1 ff 32 00000000000000000000000000000000 1  1 fe 32 00000000000000000000000000003330 1  A327A326A325A324A323A322A321A320 A327A326A325A324A323A322A3213330
1 ff 32 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  A327A326A325A324A323A322A3213330 A327A326A325A324A323A322A3213330
1 ff 70 00000000000000000000000000000000 1  1 00 71 0102030405060708090A0B0C0D0E0F10 1  00000000000000000000000000000000 00000000000000000000000000000000
1 ff 31 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  B317B316B315B314B313B312B311B310 00000000000000000000000000000000
1 ff 33 00000000000000000000000000000000 0  0 ff 00 00000000000000000000000000000000 0  00000000000000000000000000000000 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  B337B336B335B334B333B332B331B330 00000000000000000000000000000000
0 ff 00 00000000000000000000000000000000 1  1 ff 37 00000000000000000000000000000000 1  B337B336B335B334B333B332B331B330 B377B376B375B374B373B372B371B370
1 3c 00 77776666555544443333222211110000 1  1 ff 00 00000000000000000000000000000000 1  77776666E005E004E003E00211110000 E007E006E005E004E003E002E001E000
0 ff 00 00000000000000000000000000000000 1  1 ff 00 00000000000000000000000000000000 1  77776666E005E004E003E00211110000 77776666E005E004E003E00211110000
1 00 01 A017A016A015A014A013A012A011A010 1  1 00 02 B027B026B025B024B023B022B021B020 1  A017A016A015A014A013A012A011A010 B027B026B025B024B023B022B021B020
1 00 03 A037A036A035A034A033A032A031A030 1  1 00 04 B047B046B045B044B043B042B041B040 1  A037A036A035A034A033A032A031A030 B047B046B045B044B043B042B041B040
1 ff 02 00000000000000000000000000000000 1  1 ff 01 00000000000000000000000000000000 1  B027B026B025B024B023B022B021B020 A017A016A015A014A013A012A011A010
1 ff 04 00000000000000000000000000000000 1  1 ff 03 00000000000000000000000000000000 1  B047B046B045B044B043B042B041B040 A037A036A035A034A033A032A031A030
1 ff 51 00000000000000000000000000000000 1  1 ff 05 00000000000000000000000000000000 1  00000000000000000000000000000000 5A075A065A055A045A035A025A015A00
0 ff 00 00000000000000000000000000000000 1  0 ff 00 00000000000000000000000000000000 1  00000000000000000000000000000000 5A075A065A055A045A035A025A015A00
1 ff 01 00000000000000000000000000000000 1  1 ff 4f 00000000000000000000000000000000 1  A017A016A015A014A013A012A011A010 4F074F064F054F044F034F024F014F00

// ==== project.f ====
+incdir+design
design/ram_pkg.sv
design/byteLane.sv
design/ramPort.sv
design/dualPortRam.sv
test/dualPortRam_asserts.sv
test/dualPortRam_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the dual-port memory testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module dualPortRam_tb -Mdir obj_dir -f project.f

status=0
output=$(./obj_dir/VdualPortRam_tb +verilator+error+limit+1000) || status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

// ==== test/dualPortRam_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

// Testbench for the dual-port memory.
// Each stimulus row drives both ports for one cycle and gives the
// outputs expected on the falling edge one cycle later.
module dualPortRam_tb
  import ram_pkg::*;
();

  localparam int clockPeriod  = 40;
  localparam int resetCycles  = 8;
  localparam int marginCycles = 10;
  localparam string stimFile  = "test/dualPortRam_stim.txt";

  // One cycle of stimulus together with its expected outputs.
  typedef struct packed {
    portReqT  reqA;
    logic     oeA;
    portReqT  reqB;
    logic     oeB;
    wordDataT expA;
    wordDataT expB;
  } stimRowT;

  logic     CKA = 1'b0;
  logic     rstN;
  portReqT  reqA;
  portReqT  reqB;
  logic     oeA;
  logic     oeB;
  wordDataT doA;
  wordDataT doB;

  stimRowT     rows[$];
  int          errorCount = 0;
  int          fileErrors = 0;
  int unsigned assertFails = 0;
  bit          loadDone = 1'b0;

  always #(clockPeriod / 2) CKA = ~CKA;

  dualPortRam dut0 (
    .CKA  (CKA),
    .rstN (rstN),
    .reqA (reqA),
    .reqB (reqB),
    .oeA  (oeA),
    .oeB  (oeB),
    .doA  (doA),
    .doB  (doB)
  );

  // Reads every data row of the stimulus file into the row queue.
  // Lines that start with a hash are comments.
  task automatic loadStimulus();
    int       fd;
    int       code;
    int       lineNo;
    string    text;
    logic     selA;
    logic     selB;
    logic     oeAIn;
    logic     oeBIn;
    laneMaskT weNA;
    laneMaskT weNB;
    addrT     addrA;
    addrT     addrB;
    wordDataT dataA;
    wordDataT dataB;
    wordDataT expA;
    wordDataT expB;
    stimRowT  row;
    fd = $fopen(stimFile, "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file %s", stimFile);
      fileErrors++;
      return;
    end
    lineNo = 0;
    while (!$feof(fd))
    begin
      text = "";
      code = $fgets(text, fd);
      lineNo++;
      if (code > 0 && text.len() >= 2 && text[0] != "#")
      begin
        code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h",
                       selA, weNA, addrA, dataA, oeAIn,
                       selB, weNB, addrB, dataB, oeBIn, expA, expB);
        if (code != 12)
        begin
          $display("Stimulus line %0d is malformed and was skipped", lineNo);
          fileErrors++;
        end
        else
        begin
          row.reqA.sel  = selA;
          row.reqA.weN  = weNA;
          row.reqA.addr = addrA;
          row.reqA.data = dataA;
          row.oeA       = oeAIn;
          row.reqB.sel  = selB;
          row.reqB.weN  = weNB;
          row.reqB.addr = addrB;
          row.reqB.data = dataB;
          row.oeB       = oeBIn;
          row.expA      = expA;
          row.expB      = expB;
          rows.push_back(row);
        end
      end
    end
    $fclose(fd);
    if (rows.size() == 0)
    begin
      $display("The stimulus file holds no data rows");
      fileErrors++;
    end
  endtask

  task automatic checkValue(input wordDataT actual, input wordDataT expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      errorCount++;
    end
  endtask

  task automatic driveRow(input stimRowT row);
    reqA = row.reqA;
    oeA  = row.oeA;
    reqB = row.reqB;
    oeB  = row.oeB;
  endtask

  task automatic checkRow(input stimRowT row, input int index);
    checkValue(doA, row.expA, $sformatf("doA after row %0d", index));
    checkValue(doB, row.expB, $sformatf("doB after row %0d", index));
  endtask

  initial
  begin : stimulus
    int i;
    rstN = 1'b0;
    reqA = '0;
    reqB = '0;
    // Outputs stay enabled through reset so the cleared registers are visible.
    oeA  = 1'b1;
    oeB  = 1'b1;
    loadStimulus();
    loadDone = 1'b1;
    repeat (resetCycles) @(negedge CKA);
    rstN = 1'b1;
    // Row i is checked on the edge that drives row i + 1.
    for (i = 0; i < rows.size(); i++)
    begin
      @(negedge CKA);
      if (i > 0)
      begin
        checkRow(rows[i - 1], i - 1);
      end
      driveRow(rows[i]);
    end
    @(negedge CKA);
    if (rows.size() > 0)
    begin
      checkRow(rows[rows.size() - 1], rows.size() - 1);
    end
    assertFails = dut0.asserts0.failCount;
    $display("Done: %0d value mismatches, %0d stimulus file problems, %0d assertion failures",
             errorCount, fileErrors, assertFails);
    if (errorCount == 0 && fileErrors == 0 && assertFails == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

  // The limit covers reset, every row and a margin.
  initial
  begin : watchdog
    int limitNs;
    wait (loadDone);
    limitNs = (rows.size() + resetCycles + marginCycles) * clockPeriod;
    #(limitNs);
    $display("Timeout: the run did not finish within %0d ns", limitNs);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/dualPortRam_asserts.sv ====
`default_nettype none
`timescale 1ns/100ps

// Concurrent checks on the outputs of the dual-port memory.
module dualPortRam_asserts
  import ram_pkg::*;
(
  input logic     CKA,
  input logic     rstN,
  input portReqT  reqA,
  input portReqT  reqB,
  input logic     oeA,
  input logic     oeB,
  input wordDataT doA,
  input wordDataT doB
);

  // Number of assertion failures so far.
  int unsigned failCount = 0;

  // A port with its output enable low drives zero.
  oeLowZeroA: assert property (@(posedge CKA) disable iff (!rstN) !oeA |-> doA == '0)
  else
  begin
    failCount++;
    $error("doA is not zero while oeA is low");
  end

  oeLowZeroB: assert property (@(posedge CKA) disable iff (!rstN) !oeB |-> doB == '0)
  else
  begin
    failCount++;
    $error("doB is not zero while oeB is low");
  end

  // Both output registers come out of reset cleared.
  resetClear: assert property (@(posedge CKA) $rose(rstN) |-> (doA == '0 && doB == '0))
  else
  begin
    failCount++;
    $error("outputs are not zero in the first cycle after reset");
  end

  // An unselected port holds its output register.
  holdA: assert property (@(posedge CKA) disable iff (!rstN)
    (!$past(reqA.sel) && $past(oeA) && oeA) |-> $stable(doA))
  else
  begin
    failCount++;
    $error("doA changed across an edge without a select");
  end

  holdB: assert property (@(posedge CKA) disable iff (!rstN)
    (!$past(reqB.sel) && $past(oeB) && oeB) |-> $stable(doB))
  else
  begin
    failCount++;
    $error("doB changed across an edge without a select");
  end

endmodule

bind dualPortRam dualPortRam_asserts asserts0 (
  .CKA  (CKA),
  .rstN (rstN),
  .reqA (reqA),
  .reqB (reqB),
  .oeA  (oeA),
  .oeB  (oeB),
  .doA  (doA),
  .doB  (doB)
);

`default_nettype wire

// ==== design/dualPortRam.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ram_params.svh"

// Dual-port memory of RAM_WORDS words, split into RAM_LANES byte lanes.
// Both ports share CKA, and each has a one-cycle registered output.
module dualPortRam
  import ram_pkg::*;
(
  input  logic     CKA,
  input  logic     rstN,

  // Port requests.
  input  portReqT  reqA,
  input  portReqT  reqB,

  // Output enables.
  input  logic     oeA,
  input  logic     oeB,

  // Registered read data.
  output wordDataT doA,
  output wordDataT doB
);

  // Lane writes from each port.
  laneWriteT [`RAM_LANES-1:0] laneWrA;
  laneWriteT [`RAM_LANES-1:0] laneWrB;

  // Read addresses from each port.
  addrT rdAddrA;
  addrT rdAddrB;

  // Words gathered from the lane columns for each port.
  wordDataT rdWordA;
  wordDataT rdWordB;

  ramPort portA (
    .CKA    (CKA),
    .rstN   (rstN),
    .req    (reqA),
    .oe     (oeA),
    .laneWr (laneWrA),
    .rdAddr (rdAddrA),
    .rdData (rdWordA),
    .dout   (doA)
  );

  ramPort portB (
    .CKA    (CKA),
    .rstN   (rstN),
    .req    (reqB),
    .oe     (oeB),
    .laneWr (laneWrB),
    .rdAddr (rdAddrB),
    .rdData (rdWordB),
    .dout   (doB)
  );

  // One storage column per byte lane.
  // Column i returns lane i of the addressed word to each port.
  for (genvar i = 0; i < `RAM_LANES; i++)
  begin : lane
    byteLane column (
      .CKA     (CKA),
      .wrA     (laneWrA[i]),
      .wrB     (laneWrB[i]),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdDataA (rdWordA[i]),
      .rdDataB (rdWordB[i])
    );
  end

endmodule

`default_nettype wire

// ==== design/ramPort.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ram_params.svh"

// Request side of one memory port.
// It turns the request into per-lane writes, picks the read address,
// and holds the registered output word.
module ramPort
  import ram_pkg::*;
(
  input  logic                         CKA,
  input  logic                         rstN,

  // Request and output enable from outside.
  input  portReqT                      req,
  input  logic                         oe,

  // One write per lane column.
  output laneWriteT [`RAM_LANES-1:0]   laneWr,

  // Shared read address for all lane columns and the word they return.
  output addrT                         rdAddr,
  input  wordDataT                     rdData,

  // Registered word, forced to zero while oe is low.
  output wordDataT                     dout
);

  // First address past the end of the array.
  localparam addrT wordCount = addrT'(`RAM_WORDS);

  logic     inRange;
  logic     reqValid;
  laneMaskT wrEn;
  wordDataT nextOut;
  wordDataT outReg;

  // Addresses from RAM_WORDS upwards do not exist.
  assign inRange  = (req.addr < wordCount);
  assign reqValid = req.sel & inRange;

  // A lane is written when the request is live and its enable is low.
  assign wrEn = {`RAM_LANES{reqValid}} & ~req.weN;

  // Lane writes are combinational and land in the columns at this edge.
  always_comb
  begin
    for (int i = 0; i < `RAM_LANES; i++)
    begin
      laneWr[i].en   = wrEn[i];
      laneWr[i].addr = req.addr;
      laneWr[i].data = req.data[i];
    end
  end

  // Keep the array index inside the storage for out-of-range requests.
  // Their read data is discarded below in any case.
  assign rdAddr = inRange ? req.addr : '0;

  // Written lanes pass the new data straight through.
  // Other lanes take the contents from before the edge.
  always_comb
  begin
    if (!inRange)
    begin
      nextOut = '0;
    end
    else
    begin
      for (int i = 0; i < `RAM_LANES; i++)
      begin
        if (wrEn[i])
        begin
          nextOut[i] = req.data[i];
        end
        else
        begin
          nextOut[i] = rdData[i];
        end
      end
    end
  end

  // Loads on a selected cycle and holds otherwise.
  always_ff @(posedge CKA or negedge rstN)
  begin
    if (!rstN)
    begin
      outReg <= '0;
    end
    else if (req.sel)
    begin
      outReg <= nextOut;
    end
  end

  // A disabled port drives zero rather than floating.
  assign dout = oe ? outReg : '0;

endmodule

`default_nettype wire

// ==== design/byteLane.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ram_params.svh"

// One 16-bit column of the memory.
// Every word keeps its lane N in the column of lane N, so the top level
// builds a full word from eight of these columns side by side.
module byteLane
  import ram_pkg::*;
(
  input  logic      CKA,

  // Write ports, one per memory port.
  input  laneWriteT wrA,
  input  laneWriteT wrB,

  // Read addresses, one per memory port.
  input  addrT      rdAddrA,
  input  addrT      rdAddrB,

  // Stored contents at the read addresses.
  output laneDataT  rdDataA,
  output laneDataT  rdDataB
);

  // Storage for this lane of every word.
  laneDataT mem [`RAM_WORDS];

  // Port B is applied first and port A last.
  // When both ports hit the same word in one cycle the later
  // nonblocking assignment is the one that sticks, so port A wins.
  always_ff @(posedge CKA)
  begin
    if (wrB.en)
    begin
      mem[wrB.addr] <= wrB.data;
    end
    if (wrA.en)
    begin
      mem[wrA.addr] <= wrA.data;
    end
  end

  // Reads are combinational and see the array as it stands before
  // the coming edge.
  // A port that reads while the other port writes the same word
  // therefore returns the old contents.
  always_comb
  begin
    rdDataA = mem[rdAddrA];
  end

  always_comb
  begin
    rdDataB = mem[rdAddrB];
  end

endmodule

`default_nettype wire

// ==== design/ram_pkg.sv ====
`default_nettype none

`include "ram_params.svh"

package ram_pkg;

  // Word address.
  // Values of RAM_WORDS and above are out of range.
  typedef logic [`RAM_ADDR_BITS-1:0] addrT;

  // Contents of one byte lane.
  typedef logic [`RAM_LANE_BITS-1:0] laneDataT;

  // A full word.
  // Lane 0 sits in the lowest bits.
  typedef laneDataT [`RAM_LANES-1:0] wordDataT;

  // One bit per lane, used for the active-low write enables.
  typedef logic [`RAM_LANES-1:0] laneMaskT;

  // Everything a port presents in one cycle.
  // The request acts on the edge where sel is high.
  typedef struct packed {
    logic     sel;
    laneMaskT weN;
    addrT     addr;
    wordDataT data;
  } portReqT;

  // A write from one port into one lane column.
  // The port has already qualified en with select, range and mask.
  typedef struct packed {
    logic     en;
    addrT     addr;
    laneDataT data;
  } laneWriteT;

endpackage

`default_nettype wire

// ==== design/ram_params.svh ====
`ifndef RAM_PARAMS_SVH
`define RAM_PARAMS_SVH

// Geometry of the dual-port memory.

// Width of a word address.
// It covers 128 locations, of which only the first RAM_WORDS exist.
`define RAM_ADDR_BITS 7

// Number of words held in the array.
`define RAM_WORDS 80

// Width of one byte lane.
`define RAM_LANE_BITS 16

// Byte lanes per word.
// A full word is RAM_LANES * RAM_LANE_BITS bits wide.
`define RAM_LANES 8

`endif
